// File: Bender.yml
package:
  name: ex_mem_pipe

export_include_dirs:
  - src

sources:
  - src/ex_pkg.sv
  - src/alu.sv
  - src/mul_unit.sv
  - src/div_unit.sv
  - src/data_ram.sv
  - src/ex_stage.sv
  - src/mem_stage.sv
  - src/ex_top.sv
  - target: test
    files:
      - bench/ex_tb.sv

// File: all.f
+incdir+src
src/ex_pkg.sv
src/alu.sv
src/mul_unit.sv
src/div_unit.sv
src/data_ram.sv
src/ex_stage.sv
src/mem_stage.sv
src/ex_top.sv
bench/ex_tb.sv

// File: bench/ex_patterns.txt
// gap_mdop_aluop_ctl_waddr_src1_src2_rkdvalue_pc_expectedwdata (hex, one-hot ops as in ex_pkg)
// ctl bits: 2 load, 1 store, 0 rf_we
00_00_001_1_01_00000003_00000004_00000000_1c000000_00000007
00_00_001_1_02_7fffffff_00000001_00000000_1c000004_80000000
01_00_002_1_03_00000005_00000007_00000000_1c000008_fffffffe
00_00_004_1_04_fffffffe_00000001_00000000_1c00000c_00000001
00_00_008_1_05_fffffffe_00000001_00000000_1c000010_00000000
02_00_010_1_06_f0f0ff00_0ff0f0f0_00000000_1c000014_00f0f000
00_00_020_1_07_12345678_0f0f0000_00000000_1c000018_e0c0a987
00_00_040_1_08_12340000_00005678_00000000_1c00001c_12345678
00_00_080_1_09_ffff0000_0f0f0f0f_00000000_1c000020_f0f00f0f
00_00_100_1_0a_00000001_00000024_00000000_1c000024_00000010
00_00_200_1_0b_80000000_0000001f_00000000_1c000028_00000001
01_00_400_1_0c_80000010_00000004_00000000_1c00002c_f8000001
00_00_800_1_0d_deadbeef_12345000_00000000_1c000030_12345000
00_40_000_1_0e_00000007_fffffffd_00000000_1c000034_ffffffeb
00_20_000_1_0f_00000007_fffffffd_00000000_1c000038_ffffffff
00_10_000_1_10_00000007_fffffffd_00000000_1c00003c_00000006
00_20_000_1_11_80000000_80000000_00000000_1c000040_40000000
00_10_000_1_12_ffffffff_ffffffff_00000000_1c000044_fffffffe
00_08_000_1_13_fffffff9_00000002_00000000_1c000048_fffffffd
00_04_000_1_14_fffffff9_00000002_00000000_1c00004c_ffffffff
00_08_000_1_15_00000007_fffffffe_00000000_1c000050_fffffffd
00_04_000_1_16_00000007_fffffffe_00000000_1c000054_00000001
00_02_000_1_17_fffffff9_00000002_00000000_1c000058_7ffffffc
00_01_000_1_18_fffffff9_00000002_00000000_1c00005c_00000001
00_08_000_1_19_00000005_00000000_00000000_1c000060_ffffffff
00_04_000_1_1a_fffffffb_00000000_00000000_1c000064_fffffffb
00_02_000_1_1b_12345678_00000000_00000000_1c000068_ffffffff
00_01_000_1_1c_12345678_00000000_00000000_1c00006c_12345678
00_08_000_1_1d_80000000_ffffffff_00000000_1c000070_80000000
00_04_000_1_1e_80000000_ffffffff_00000000_1c000074_00000000
00_00_001_1_1f_00000100_00000023_00000000_1c000078_00000123
00_00_080_1_01_0000ffff_00000f0f_00000000_1c00007c_0000f0f0
00_00_001_2_00_00000010_00000005_cafef00d_1c000080_00000015
00_00_001_2_00_00000100_000000ff_5a5aa5a5_1c000084_000001ff
01_00_001_5_05_00000015_00000000_00000000_1c000088_cafef00d
00_00_001_5_06_000000f0_0000000f_00000000_1c00008c_5a5aa5a5
00_00_001_2_00_00000030_00000000_13579bdf_1c000090_00000030
00_00_001_5_08_00000000_00000030_00000000_1c000094_13579bdf

// File: bench/ex_tb.sv
`timescale 1ns/1ps

`include "ex_settings.svh"

module ex_tb
  import ex_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_PATS     = 64;
  localparam int SEED         = 32'h6913_d736;

  // one line of the pattern file, fields on nibble boundaries
  typedef struct packed {
    logic [7:0]  gap;           // idle cycles before the bundle
    logic [7:0]  md_op;
    logic [11:0] alu_op;
    logic        ctl_spare;
    logic        res_from_mem;
    logic        mem_we;
    logic        rf_we;
    logic [7:0]  rf_waddr;
    word_t       src1;
    word_t       src2;
    word_t       rkd_value;
    word_t       pc;
    word_t       expected;      // writeback data
  } pattern_t;

  logic      clk = 1'b0;
  logic      resetn;
  logic      ds_to_es_valid;
  ds_to_es_t ds_to_es_bus;
  logic      es_allowin;
  logic      ws_allowin;
  logic      ms_to_ws_valid;
  ms_to_ws_t ms_to_ws_bus;

  logic [$bits(pattern_t)-1:0] pat_raw [0:MAX_PATS-1];
  int num_pats;

  ex_top UUT (
    .clk           (clk),
    .resetn        (resetn),
    .ds_to_es_valid(ds_to_es_valid),
    .ds_to_es_bus  (ds_to_es_bus),
    .es_allowin    (es_allowin),
    .ws_allowin    (ws_allowin),
    .ms_to_ws_valid(ms_to_ws_valid),
    .ms_to_ws_bus  (ms_to_ws_bus)
  );

  initial begin
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic fail_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // inputs settle well before the rising edge
  task automatic sample_point();
    @(negedge clk);
    #(CLK_PERIOD/4);
  endtask

  task automatic check_field(input int idx, input string name, input word_t exp_val,
                             input word_t act_val);
    assert (act_val === exp_val) else begin
      $display("ERR pattern %0d %s expected %h actual %h", idx, name, exp_val, act_val);
      fail_run();
    end
  endtask

  function automatic ds_to_es_t bundle_of(input pattern_t p);
    ds_to_es_t b;
    b.md_op        = p.md_op[6:0];
    b.alu_op       = p.alu_op;
    b.res_from_mem = p.res_from_mem;
    b.src1         = p.src1;
    b.src2         = p.src2;
    b.mem_we       = p.mem_we;
    b.rf_we        = p.rf_we;
    b.rf_waddr     = p.rf_waddr[4:0];
    b.rkd_value    = p.rkd_value;
    b.pc           = p.pc;
    return b;
  endfunction

  task automatic load_patterns();
    for (int i = 0; i < MAX_PATS; i++) begin
      pat_raw[i] = '0;
    end
    $readmemh("bench/ex_patterns.txt", pat_raw);
    num_pats = 0;
    while (num_pats < MAX_PATS && pat_raw[num_pats] != '0) begin
      num_pats++;
    end
  endtask

  task automatic drive_pattern(input pattern_t p);
    logic taken;
    repeat (p.gap) begin
      @(negedge clk);
      ds_to_es_valid = 1'b0;
    end
    @(negedge clk);
    ds_to_es_valid = 1'b1;
    ds_to_es_bus   = bundle_of(p);
    #(CLK_PERIOD/4);
    taken = es_allowin;
    while (!taken) begin  // hold until the stage takes it
      @(negedge clk);
      #(CLK_PERIOD/4);
      taken = es_allowin;
    end
  endtask

  task automatic run_driver();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    for (int i = 0; i < num_pats; i++) begin
      drive_pattern(pattern_t'(pat_raw[i]));
    end
    @(negedge clk);
    ds_to_es_valid = 1'b0;
  endtask

  task automatic run_backpressure();
    forever begin
      @(negedge clk);
      ws_allowin = ($urandom % 4) != 0;  // stall about one cycle in four
    end
  endtask

  task automatic run_checker();
    pattern_t p;
    int       got;
    got = 0;
    // nothing may leave during reset or just after it
    repeat (RESET_CYCLES + 2) begin
      sample_point();
      assert (ms_to_ws_valid === 1'b0) else begin
        $display("ms_to_ws_valid was high during or just after reset");
        fail_run();
      end
    end
    while (got < num_pats) begin
      sample_point();
      if (ms_to_ws_valid && ws_allowin) begin
        p = pattern_t'(pat_raw[got]);
        check_field(got, "wdata", p.expected, ms_to_ws_bus.wdata);
        check_field(got, "rf_waddr", word_t'(p.rf_waddr), word_t'(ms_to_ws_bus.rf_waddr));
        check_field(got, "rf_we", word_t'(p.rf_we), word_t'(ms_to_ws_bus.rf_we));
        check_field(got, "pc", p.pc, ms_to_ws_bus.pc);
        got++;
      end
    end
    // drained pipeline stays quiet
    repeat (8) begin
      sample_point();
      assert (ms_to_ws_valid === 1'b0) else begin
        $display("an extra writeback came out after all %0d patterns", num_pats);
        fail_run();
      end
    end
    $display("TESTS PASSED");
    $finish;
  endtask

  initial begin : main
    int seed;
    int limit;
    seed = SEED;
    void'($urandom(seed));
    resetn         = 1'b0;
    ds_to_es_valid = 1'b0;
    ds_to_es_bus   = '0;
    ws_allowin     = 1'b1;
    load_patterns();
    assert (num_pats > 0) else begin
      $display("no patterns could be read from bench/ex_patterns.txt");
      fail_run();
    end
    limit = RESET_CYCLES + num_pats * (`EX_DIV_STEPS + 20);
    fork
      run_driver();
      run_backpressure();
      run_checker();
      begin
        repeat (limit) @(posedge clk);
        $display("writebacks stopped coming out before all patterns were seen");
        fail_run();
      end
    join
  end

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu
  import ex_pkg::*;
(
  input  alu_op_t alu_op,
  input  word_t   alu_src1,
  input  word_t   alu_src2,
  output word_t   alu_result
);

  logic [4:0] shamt;
  logic       slt_bit;
  logic       sltu_bit;
  word_t      add_res;
  word_t      sub_res;
  word_t      sll_res;
  word_t      srl_res;
  word_t      sra_res;

  assign shamt    = alu_src2[4:0];  // low five bits only
  assign add_res  = alu_src1 + alu_src2;
  assign sub_res  = alu_src1 - alu_src2;
  assign slt_bit  = $signed(alu_src1) < $signed(alu_src2);
  assign sltu_bit = alu_src1 < alu_src2;
  assign sll_res  = alu_src1 << shamt;
  assign srl_res  = alu_src1 >> shamt;
  assign sra_res  = word_t'($signed(alu_src1) >>> shamt);

  // one-hot and-or select
  assign alu_result = ({$bits(word_t){alu_op[0]}}  & add_res)
                    | ({$bits(word_t){alu_op[1]}}  & sub_res)
                    | ({$bits(word_t){alu_op[2]}}  & word_t'(slt_bit))
                    | ({$bits(word_t){alu_op[3]}}  & word_t'(sltu_bit))
                    | ({$bits(word_t){alu_op[4]}}  & (alu_src1 & alu_src2))
                    | ({$bits(word_t){alu_op[5]}}  & ~(alu_src1 | alu_src2))
                    | ({$bits(word_t){alu_op[6]}}  & (alu_src1 | alu_src2))
                    | ({$bits(word_t){alu_op[7]}}  & (alu_src1 ^ alu_src2))
                    | ({$bits(word_t){alu_op[8]}}  & sll_res)
                    | ({$bits(word_t){alu_op[9]}}  & srl_res)
                    | ({$bits(word_t){alu_op[10]}} & sra_res)
                    | ({$bits(word_t){alu_op[11]}} & alu_src2);  // lui

endmodule

// File: src/data_ram.sv
`timescale 1ns/1ps

`include "ex_settings.svh"

module data_ram
  import ex_pkg::*;
(
  input  logic                  clk,
  input  logic                  en,
  input  logic [3:0]            we,
  input  logic [`EX_RAM_AW-1:0] addr,
  input  word_t                 wdata,
  output word_t                 rdata
);

  word_t mem [0:(1 << `EX_RAM_AW)-1];

  always_ff @(posedge clk) begin
    if (en) begin
      for (int b = 0; b < 4; b++) begin
        if (we[b]) begin
          mem[addr][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
      rdata <= mem[addr];  // old data on a write
    end
  end

endmodule

// File: src/div_unit.sv
`timescale 1ns/1ps

`include "ex_settings.svh"

module div_unit
  import ex_pkg::*;
(
  input  logic  clk,
  input  logic  resetn,
  input  logic  div_start,
  input  logic  div_signed,
  input  word_t dividend,
  input  word_t divisor,
  output word_t quotient,
  output word_t remainder,
  output logic  div_done
);

  localparam int CNT_W = $clog2(`EX_DIV_STEPS + 1);

  div_state_t         state;
  logic [CNT_W-1:0]   step_cnt;
  word_t              dvsr;
  word_t              quo;       // dividend shifts out as quotient shifts in
  word_t              rem;
  logic               q_neg;
  logic               r_neg;
  word_t              dividend_mag;
  word_t              divisor_mag;
  logic [`EX_DATA_W:0] trial_rem;
  logic [`EX_DATA_W:0] trial_diff;

  assign dividend_mag = (div_signed & dividend[`EX_DATA_W-1]) ? -dividend : dividend;
  assign divisor_mag  = (div_signed & divisor[`EX_DATA_W-1])  ? -divisor  : divisor;

  // next partial remainder and its trial subtraction
  assign trial_rem  = {rem, quo[`EX_DATA_W-1]};
  assign trial_diff = trial_rem - {1'b0, dvsr};

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state    <= DIV_IDLE;
      step_cnt <= '0;
    end else if (div_start) begin
      state    <= DIV_BUSY;
      step_cnt <= '0;
    end else if (state == DIV_BUSY) begin
      step_cnt <= step_cnt + 1'b1;
      if (step_cnt == CNT_W'(`EX_DIV_STEPS - 1)) begin
        state <= DIV_DONE;  // holds until the next start
      end
    end
  end

  always_ff @(posedge clk) begin
    if (div_start) begin
      quo   <= dividend_mag;
      rem   <= '0;
      dvsr  <= divisor_mag;
      // divide by zero keeps the all-ones quotient unsigned
      q_neg <= div_signed & (dividend[`EX_DATA_W-1] ^ divisor[`EX_DATA_W-1]) & (|divisor);
      r_neg <= div_signed & dividend[`EX_DATA_W-1];
    end else if (state == DIV_BUSY) begin
      if (!trial_diff[`EX_DATA_W]) begin
        rem <= trial_diff[`EX_DATA_W-1:0];
        quo <= {quo[`EX_DATA_W-2:0], 1'b1};
      end else begin
        rem <= trial_rem[`EX_DATA_W-1:0];  // restore
        quo <= {quo[`EX_DATA_W-2:0], 1'b0};
      end
    end
  end

  // signs applied on the way out, remainder follows the dividend
  assign quotient  = q_neg ? -quo : quo;
  assign remainder = r_neg ? -rem : rem;
  assign div_done  = (state == DIV_DONE);

endmodule

// File: src/ex_pkg.sv
`include "ex_settings.svh"

package ex_pkg;

  typedef logic [`EX_DATA_W-1:0] word_t;
  typedef logic [4:0]            reg_addr_t;

  // one-hot, bit 0 upwards: add sub slt sltu and nor or xor sll srl sra lui
  typedef logic [11:0] alu_op_t;

  // one-hot, bit 6 downwards: mul_w mulh_w mulh_wu div_w mod_w div_wu mod_wu
  // all zero for a plain alu instruction
  typedef logic [6:0] md_op_t;

  typedef struct packed {
    md_op_t    md_op;
    alu_op_t   alu_op;
    logic      res_from_mem;  // load
    word_t     src1;
    word_t     src2;
    logic      mem_we;        // store
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rkd_value;     // store data
    word_t     pc;
  } ds_to_es_t;

  typedef struct packed {
    logic      res_from_mem;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     result;
    word_t     pc;
  } es_to_ms_t;

  typedef struct packed {
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     wdata;
    word_t     pc;
  } ms_to_ws_t;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_BUSY,
    DIV_DONE
  } div_state_t;

endpackage

// File: src/ex_settings.svh
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// machine word width
`define EX_DATA_W 32

// data ram word-address bits, 256 words
`define EX_RAM_AW 8

// one restoring step per quotient bit
`define EX_DIV_STEPS `EX_DATA_W

`endif

// File: src/ex_stage.sv
`timescale 1ns/1ps

module ex_stage
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      resetn,
  input  logic      ds_to_es_valid,
  input  ds_to_es_t ds_to_es_bus,
  output logic      es_allowin,
  input  logic      ms_allowin,
  output logic      es_to_ms_valid,
  output es_to_ms_t es_to_ms_bus,
  output logic      data_sram_en,
  output logic [3:0] data_sram_we,
  output word_t     data_sram_addr,
  output word_t     data_sram_wdata
);

  logic      es_valid;
  ds_to_es_t es_bus;
  logic      es_ready_go;
  logic      es_leave;
  logic      is_mul;
  logic      is_div;
  logic      is_quot;
  logic      div_signed;
  logic      div_start;
  logic      div_started;
  logic      div_done;
  word_t     quotient;
  word_t     remainder;
  word_t     alu_result;
  word_t     mul_result;
  word_t     div_result;
  word_t     es_result;

  // op decode
  assign is_mul     = |es_bus.md_op[6:4];
  assign is_div     = |es_bus.md_op[3:0];
  assign is_quot    = es_bus.md_op[3] | es_bus.md_op[1];  // div.w, div.wu
  assign div_signed = es_bus.md_op[3] | es_bus.md_op[2];

  // stall on a divide until the result for this bundle is back
  assign es_ready_go    = is_div ? (div_started & div_done) : 1'b1;
  assign es_allowin     = ~es_valid | (es_ready_go & ms_allowin);
  assign es_to_ms_valid = es_valid & es_ready_go;
  assign es_leave       = es_to_ms_valid & ms_allowin;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      es_valid <= 1'b0;
    end else if (es_allowin) begin
      es_valid <= ds_to_es_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ds_to_es_valid & es_allowin) begin
      es_bus <= ds_to_es_bus;
    end
  end

  // one start pulse per divide bundle
  assign div_start = es_valid & is_div & ~div_started;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      div_started <= 1'b0;
    end else if (es_leave) begin
      div_started <= 1'b0;
    end else if (div_start) begin
      div_started <= 1'b1;
    end
  end

  alu u_alu (
    .alu_op    (es_bus.alu_op),
    .alu_src1  (es_bus.src1),
    .alu_src2  (es_bus.src2),
    .alu_result(alu_result)
  );

  mul_unit u_mul (
    .md_op     (es_bus.md_op),
    .src1      (es_bus.src1),
    .src2      (es_bus.src2),
    .mul_result(mul_result)
  );

  div_unit u_div (
    .clk       (clk),
    .resetn    (resetn),
    .div_start (div_start),
    .div_signed(div_signed),
    .dividend  (es_bus.src1),
    .divisor   (es_bus.src2),
    .quotient  (quotient),
    .remainder (remainder),
    .div_done  (div_done)
  );

  assign div_result = is_quot ? quotient : remainder;
  assign es_result  = is_mul ? mul_result : (is_div ? div_result : alu_result);

  // ram request in the same cycle as the result
  assign data_sram_en    = es_valid & (es_bus.res_from_mem | es_bus.mem_we);
  assign data_sram_we    = {4{es_valid & es_bus.mem_we}};
  assign data_sram_addr  = es_result;
  assign data_sram_wdata = es_bus.rkd_value;

  assign es_to_ms_bus.res_from_mem = es_bus.res_from_mem;
  assign es_to_ms_bus.rf_we        = es_bus.rf_we & es_valid;
  assign es_to_ms_bus.rf_waddr     = es_bus.rf_waddr;
  assign es_to_ms_bus.result       = es_result;
  assign es_to_ms_bus.pc           = es_bus.pc;

endmodule

// File: src/ex_top.sv
`timescale 1ns/1ps

`include "ex_settings.svh"

module ex_top
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      resetn,
  input  logic      ds_to_es_valid,
  input  ds_to_es_t ds_to_es_bus,
  output logic      es_allowin,
  input  logic      ws_allowin,
  output logic      ms_to_ws_valid,
  output ms_to_ws_t ms_to_ws_bus
);

  logic       ms_allowin;
  logic       es_to_ms_valid;
  es_to_ms_t  es_to_ms_bus;
  logic       data_sram_en;
  logic [3:0] data_sram_we;
  word_t      data_sram_addr;
  word_t      data_sram_wdata;
  word_t      data_sram_rdata;

  ex_stage u_ex (
    .clk            (clk),
    .resetn         (resetn),
    .ds_to_es_valid (ds_to_es_valid),
    .ds_to_es_bus   (ds_to_es_bus),
    .es_allowin     (es_allowin),
    .ms_allowin     (ms_allowin),
    .es_to_ms_valid (es_to_ms_valid),
    .es_to_ms_bus   (es_to_ms_bus),
    .data_sram_en   (data_sram_en),
    .data_sram_we   (data_sram_we),
    .data_sram_addr (data_sram_addr),
    .data_sram_wdata(data_sram_wdata)
  );

  // word index, upper bits dropped
  data_ram u_ram (
    .clk  (clk),
    .en   (data_sram_en),
    .we   (data_sram_we),
    .addr (data_sram_addr[`EX_RAM_AW-1:0]),
    .wdata(data_sram_wdata),
    .rdata(data_sram_rdata)
  );

  mem_stage u_mem (
    .clk            (clk),
    .resetn         (resetn),
    .es_to_ms_valid (es_to_ms_valid),
    .es_to_ms_bus   (es_to_ms_bus),
    .ms_allowin     (ms_allowin),
    .data_sram_rdata(data_sram_rdata),
    .ws_allowin     (ws_allowin),
    .ms_to_ws_valid (ms_to_ws_valid),
    .ms_to_ws_bus   (ms_to_ws_bus)
  );

endmodule

// File: src/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
  import ex_pkg::*;
(
  input  logic      clk,
  input  logic      resetn,
  input  logic      es_to_ms_valid,
  input  es_to_ms_t es_to_ms_bus,
  output logic      ms_allowin,
  input  word_t     data_sram_rdata,
  input  logic      ws_allowin,
  output logic      ms_to_ws_valid,
  output ms_to_ws_t ms_to_ws_bus
);

  logic      ms_valid;
  es_to_ms_t ms_bus;
  logic      ms_fresh;  // first cycle of the bundle, ram data live
  word_t     ld_hold;
  word_t     ld_data;

  assign ms_allowin = ~ms_valid | ws_allowin;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ms_valid <= 1'b0;
    end else if (ms_allowin) begin
      ms_valid <= es_to_ms_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (es_to_ms_valid & ms_allowin) begin
      ms_bus <= es_to_ms_bus;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ms_fresh <= 1'b0;
    end else begin
      ms_fresh <= es_to_ms_valid & ms_allowin;
    end
  end

  // ram output may move on while we stall, keep our copy
  always_ff @(posedge clk) begin
    if (ms_fresh) begin
      ld_hold <= data_sram_rdata;
    end
  end

  assign ld_data = ms_fresh ? data_sram_rdata : ld_hold;

  assign ms_to_ws_valid        = ms_valid;
  assign ms_to_ws_bus.rf_we    = ms_bus.rf_we & ms_valid;
  assign ms_to_ws_bus.rf_waddr = ms_bus.rf_waddr;
  assign ms_to_ws_bus.wdata    = ms_bus.res_from_mem ? ld_data : ms_bus.result;
  assign ms_to_ws_bus.pc       = ms_bus.pc;

endmodule

// File: src/mul_unit.sv
`timescale 1ns/1ps

`include "ex_settings.svh"

module mul_unit
  import ex_pkg::*;
(
  input  md_op_t md_op,
  input  word_t  src1,
  input  word_t  src2,
  output word_t  mul_result
);

  logic [2*`EX_DATA_W-1:0] signed_prod;
  logic [2*`EX_DATA_W-1:0] unsigned_prod;

  // operands extend to the full product width before multiplying
  assign signed_prod   = $signed(src1) * $signed(src2);
  assign unsigned_prod = src1 * src2;

  assign mul_result =
      ({`EX_DATA_W{md_op[6]}} & signed_prod[`EX_DATA_W-1:0])             // mul.w
    | ({`EX_DATA_W{md_op[5]}} & signed_prod[2*`EX_DATA_W-1:`EX_DATA_W])  // mulh.w
    | ({`EX_DATA_W{md_op[4]}} & unsigned_prod[2*`EX_DATA_W-1:`EX_DATA_W]);

endmodule
